/* rv_pkg.sv */
`default_nettype none

package rv_pkg;

    localparam int xlen = 64;

    // address map
    localparam logic [xlen-1:0] ram_base = 64'h0000_0000_8000_0000; // reset pc, program start
    localparam logic [xlen-1:0] isr_base = 64'h0000_0000_0000_0000; // single handler entry
    localparam logic [xlen-1:0] key_base = 64'h0000_0000_1000_0000; // key port, custom load
    localparam logic [xlen-1:0] art_base = 64'h0000_0000_1000_0008; // art port, custom store

    // machine csr indices still decoded by the read mux
    localparam logic [11:0] csr_mstatus = 12'h300;
    localparam logic [11:0] csr_mepc    = 12'h341;
    localparam logic [11:0] csr_mcause  = 12'h342;

    localparam int mstatus_mie_bit  = 3;
    localparam int mstatus_mpie_bit = 7;
    localparam logic [xlen-1:0] mstatus_reset = 64'h0000_0000_0000_0008; // mie on out of reset

    localparam logic [3:0] irq_external = 4'd1; // only vector code handled

    // board led divider
    localparam int hb_half_period = 4;
    localparam int hb_count_width = ($clog2(hb_half_period) > 0) ? $clog2(hb_half_period) : 1;
    localparam logic [hb_count_width-1:0] hb_last = hb_count_width'(hb_half_period - 1);

    // instruction encodings
    localparam logic [31:0] insn_nop       = 32'h0000_0001; // ir reset word, no match
    localparam logic [31:0] insn_mret      = 32'h0000_0000; // all zero word
    localparam logic [31:0] insn_load_key  = 32'hffff_ffff; // custom, x5 <= key port
    localparam logic [31:0] insn_store_art = 32'hffff_ff7f; // custom, art port <= x5
    localparam logic [6:0]  opc_lui        = 7'b0110111;
    localparam logic [6:0]  opc_addi       = 7'b0010011; // op-imm, funct3 000 only

    localparam logic [4:0] reg_x5 = 5'd5; // fixed data register of the custom ops

    typedef enum logic [2:0] {
        op_nop,
        op_lui,
        op_addi,
        op_load_key,
        op_store_art,
        op_mret
    } op_t;

    typedef struct packed {
        op_t             op;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [xlen-1:0] imm;   // already sign extended
    } decoded_t;

    typedef struct packed {
        logic [xlen-1:0] address;
        logic [xlen-1:0] write_data;
        logic            write_enable;
        logic            read_enable;
    } bus_req_t;

    typedef struct packed {
        logic            enable;
        logic [4:0]      addr;
        logic [xlen-1:0] data;
    } reg_write_t;

endpackage

`default_nettype wire

/* rv_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_decode (
    input  wire [31:0]      ir,
    output rv_pkg::decoded_t decoded
);

    logic [6:0]              opcode;
    logic [2:0]              funct3;
    logic [rv_pkg::xlen-1:0] imm_u;
    logic [rv_pkg::xlen-1:0] imm_i;

    assign opcode = ir[6:0];
    assign funct3 = ir[14:12];

    // u form, upper 20 bits shifted up then sign extended
    assign imm_u = {{(rv_pkg::xlen - 32){ir[31]}}, ir[31:12], 12'b0};
    // i form, 12 bit signed
    assign imm_i = {{(rv_pkg::xlen - 12){ir[31]}}, ir[31:20]};

    always_comb begin
        decoded.op  = rv_pkg::op_nop;   // anything unknown falls through
        decoded.rd  = ir[11:7];
        decoded.rs1 = ir[19:15];
        decoded.imm = '0;

        // full word matches first, opcode field later
        if (ir == rv_pkg::insn_mret) begin
            decoded.op = rv_pkg::op_mret;
        end else if (ir == rv_pkg::insn_load_key) begin
            decoded.op = rv_pkg::op_load_key;
            decoded.rd = rv_pkg::reg_x5;    // target fixed
        end else if (ir == rv_pkg::insn_store_art) begin
            decoded.op  = rv_pkg::op_store_art;
            decoded.rs1 = rv_pkg::reg_x5;   // source fixed
        end else if (opcode == rv_pkg::opc_lui) begin
            decoded.op  = rv_pkg::op_lui;
            decoded.imm = imm_u;
        end else if (opcode == rv_pkg::opc_addi && funct3 == 3'b000) begin
            decoded.op  = rv_pkg::op_addi;
            decoded.imm = imm_i;
        end
    end

endmodule

`default_nettype wire

/* rv_regfile.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_regfile (
    input  wire                      clk,
    input  wire                      reset,
    input  wire rv_pkg::reg_write_t  write,
    input  wire [4:0]                rs1_addr,
    output logic [rv_pkg::xlen-1:0]  rs1_data,
    output logic [rv_pkg::xlen-1:0]  x5_data
);

    logic [rv_pkg::xlen-1:0] regs [32];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write.enable && write.addr != 5'd0) begin
            regs[write.addr] <= write.data;     // x0 stays zero
        end
    end

    // async reads, a write shows up next cycle
    assign rs1_data = regs[rs1_addr];
    assign x5_data  = regs[rv_pkg::reg_x5];    // feeds the art store

    // fsm must never hand over a floating target
    a_waddr_known: assert property (@(posedge clk) disable iff (!reset)
        write.enable |-> !$isunknown(write.addr));

endmodule

`default_nettype wire

/* rv_csr.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_csr (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      trap,
    input  wire [rv_pkg::xlen-1:0]   trap_pc,
    input  wire [3:0]                trap_cause,
    input  wire                      mret,
    output logic                     mie_enabled,
    output logic [rv_pkg::xlen-1:0]  mepc
);

    logic [rv_pkg::xlen-1:0] mstatus;
    logic [rv_pkg::xlen-1:0] mepc_q;
    logic [rv_pkg::xlen-1:0] mcause;
    logic [rv_pkg::xlen-1:0] mstatus_view;

    // index based read, unimplemented csrs read zero
    function automatic logic [rv_pkg::xlen-1:0] csr_read(input logic [11:0] index);
        case (index)
            rv_pkg::csr_mstatus: return mstatus;
            rv_pkg::csr_mepc:    return mepc_q;
            rv_pkg::csr_mcause:  return mcause;
            default:             return '0;
        endcase
    endfunction

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mstatus <= rv_pkg::mstatus_reset;
            mepc_q  <= '0;
            mcause  <= '0;
        end else if (trap) begin
            mepc_q  <= trap_pc;
            mcause  <= {1'b1, {(rv_pkg::xlen - 5){1'b0}}, trap_cause}; // msb marks interrupt
            mstatus[rv_pkg::mstatus_mpie_bit] <= mstatus[rv_pkg::mstatus_mie_bit];
            mstatus[rv_pkg::mstatus_mie_bit]  <= 1'b0;  // no nesting
        end else if (mret) begin
            mstatus[rv_pkg::mstatus_mie_bit]  <= mstatus[rv_pkg::mstatus_mpie_bit];
            mstatus[rv_pkg::mstatus_mpie_bit] <= 1'b1;
        end
    end

    // same read path a csr instruction would take
    always_comb begin
        mstatus_view = csr_read(rv_pkg::csr_mstatus);
        mie_enabled  = mstatus_view[rv_pkg::mstatus_mie_bit];
        mepc         = csr_read(rv_pkg::csr_mepc);     // return target for mret
    end

    // fsm gives interrupt entry priority over mret
    a_trap_mret_excl: assert property (@(posedge clk) disable iff (!reset)
        !(trap && mret));

endmodule

`default_nettype wire

/* rv_heartbeat.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_heartbeat (
    input  wire  clk,
    input  wire  reset,
    output logic heartbeat
);

    logic [rv_pkg::hb_count_width-1:0] count;

    // free running, independent of the core
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            count     <= '0;
            heartbeat <= 1'b0;
        end else if (count == rv_pkg::hb_last) begin
            count     <= '0;
            heartbeat <= ~heartbeat;    // one half period done
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* rv_exec_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_exec_fsm (
    input  wire                      clk,
    input  wire                      reset,
    input  wire rv_pkg::decoded_t    decoded,
    input  wire [rv_pkg::xlen-1:0]   rs1_data,
    input  wire [rv_pkg::xlen-1:0]   x5_data,
    input  wire [rv_pkg::xlen-1:0]   bus_read_data,
    input  wire [3:0]                interrupt_vector,
    input  wire                      mie_enabled,
    input  wire [rv_pkg::xlen-1:0]   mepc,
    output logic [rv_pkg::xlen-1:0]  pc,
    output rv_pkg::reg_write_t       reg_write,
    output rv_pkg::bus_req_t         bus_req,
    output logic                     trap,
    output logic [3:0]               trap_cause,
    output logic [rv_pkg::xlen-1:0]  trap_pc,
    output logic                     mret,
    output logic                     interrupt_ack
);

    typedef enum logic [1:0] {
        st_run,
        st_bubble,      // ir holds a wrong-path word, drop it
        st_load_wait    // load refetched, data on the bus now
    } state_t;

    state_t state;
    logic   load_armed;     // first load step issued
    logic   in_run;
    logic   take_irq;

    assign in_run   = (state == st_run);
    // never in bubble or load_wait, so a load is not split
    assign take_irq = in_run && mie_enabled && (interrupt_vector == rv_pkg::irq_external);

    assign trap       = take_irq;
    assign trap_cause = interrupt_vector;
    assign trap_pc    = pc - 64'd4;     // address of the word now in ir
    assign mret       = in_run && !take_irq && (decoded.op == rv_pkg::op_mret);

    // register writeback, lands at the edge closing this cycle
    always_comb begin
        reg_write = '0;
        if (state == st_load_wait) begin
            reg_write.enable = 1'b1;
            reg_write.addr   = rv_pkg::reg_x5;
            reg_write.data   = bus_read_data;   // held by the bus since the strobe
        end else if (in_run && !take_irq) begin
            case (decoded.op)
                rv_pkg::op_lui: begin
                    reg_write.enable = 1'b1;
                    reg_write.addr   = decoded.rd;
                    reg_write.data   = decoded.imm;
                end
                rv_pkg::op_addi: begin
                    reg_write.enable = 1'b1;
                    reg_write.addr   = decoded.rd;
                    reg_write.data   = rs1_data + decoded.imm;
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state         <= st_run;
            load_armed    <= 1'b0;
            pc            <= rv_pkg::ram_base;
            bus_req       <= '0;
            interrupt_ack <= 1'b0;
        end else begin
            pc                   <= pc + 64'd4;     // default, overridden on redirect
            bus_req.read_enable  <= 1'b0;           // strobes are single cycle
            bus_req.write_enable <= 1'b0;
            interrupt_ack        <= take_irq;       // ack one cycle after entry
            case (state)
                st_run: begin
                    if (take_irq) begin
                        pc    <= rv_pkg::isr_base;
                        state <= st_bubble;
                    end else begin
                        case (decoded.op)
                            rv_pkg::op_load_key: begin
                                bus_req.address     <= rv_pkg::key_base;
                                bus_req.read_enable <= 1'b1;
                                pc                  <= pc - 64'd4; // back to the load itself
                                load_armed          <= 1'b1;
                                state               <= st_bubble;
                            end
                            rv_pkg::op_store_art: begin
                                bus_req.address      <= rv_pkg::art_base;
                                bus_req.write_data   <= x5_data;
                                bus_req.write_enable <= 1'b1;
                            end
                            rv_pkg::op_mret: begin
                                pc    <= mepc;  // dropped insn runs again
                                state <= st_bubble;
                            end
                            default: begin
                            end
                        endcase
                    end
                end
                st_bubble: begin
                    load_armed <= 1'b0;
                    state      <= load_armed ? st_load_wait : st_run;
                end
                st_load_wait: state <= st_run;
                default:      state <= st_run;
            endcase
        end
    end

    // bus model relies on one strobe per cycle
    a_strobes_exclusive: assert property (@(posedge clk) disable iff (!reset)
        !(bus_req.read_enable && bus_req.write_enable));

    // redirects and the load step back keep word alignment
    a_pc_aligned: assert property (@(posedge clk) disable iff (!reset)
        pc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* rv_core.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_core (
    input  wire                      clk,
    input  wire                      reset,
    input  wire [31:0]               instruction,   // follows pc combinationally
    output logic [rv_pkg::xlen-1:0]  pc,
    output rv_pkg::bus_req_t         bus_req,
    input  wire [rv_pkg::xlen-1:0]   bus_read_data,
    input  wire [3:0]                interrupt_vector,
    output logic                     interrupt_ack,
    output logic                     heartbeat
);

    logic [31:0]             ir;
    rv_pkg::decoded_t        decoded;
    rv_pkg::reg_write_t      reg_write;
    logic [rv_pkg::xlen-1:0] rs1_data;
    logic [rv_pkg::xlen-1:0] x5_data;
    logic                    trap;
    logic [3:0]              trap_cause;
    logic [rv_pkg::xlen-1:0] trap_pc;
    logic                    mret;
    logic                    mie_enabled;
    logic [rv_pkg::xlen-1:0] mepc;

    // fetch latch, executed one cycle later
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ir <= rv_pkg::insn_nop;
        end else begin
            ir <= instruction;  // bubble cycles drop it in the fsm
        end
    end

    rv_decode u_decode (
        .ir      (ir),
        .decoded (decoded)
    );

    rv_regfile u_regfile (
        .clk      (clk),
        .reset    (reset),
        .write    (reg_write),
        .rs1_addr (decoded.rs1),
        .rs1_data (rs1_data),
        .x5_data  (x5_data)
    );

    rv_exec_fsm u_exec_fsm (
        .clk              (clk),
        .reset            (reset),
        .decoded          (decoded),
        .rs1_data         (rs1_data),
        .x5_data          (x5_data),
        .bus_read_data    (bus_read_data),
        .interrupt_vector (interrupt_vector),
        .mie_enabled      (mie_enabled),
        .mepc             (mepc),
        .pc               (pc),
        .reg_write        (reg_write),
        .bus_req          (bus_req),
        .trap             (trap),
        .trap_cause       (trap_cause),
        .trap_pc          (trap_pc),
        .mret             (mret),
        .interrupt_ack    (interrupt_ack)
    );

    rv_csr u_csr (
        .clk         (clk),
        .reset       (reset),
        .trap        (trap),
        .trap_pc     (trap_pc),
        .trap_cause  (trap_cause),
        .mret        (mret),
        .mie_enabled (mie_enabled),
        .mepc        (mepc)
    );

    rv_heartbeat u_heartbeat (
        .clk       (clk),
        .reset     (reset),
        .heartbeat (heartbeat)
    );

endmodule

`default_nettype wire

/* tb_rv_vectors.svh */
`ifndef TB_RV_VECTORS_SVH
`define TB_RV_VECTORS_SVH

// columns: key, use_random, addi imm (12 bit), irq, expected art value
// irq 0 none, 1 one interrupt before the row, 2 a second one raised inside the handler
// expected art is ignored for random rows, computed from the drawn key instead

typedef struct packed {
    logic [63:0] key;
    logic        use_random;
    logic [11:0] imm;
    logic [1:0]  irq;
    logic [63:0] expect_art;
} vector_t;

localparam int n_rows = 8;

localparam vector_t vectors [n_rows] = '{
    '{64'h0000_0000_0000_1000, 1'b0, 12'h005, 2'd0, 64'h0000_0000_0000_1005},
    '{64'h0000_0000_0000_0010, 1'b0, 12'hfff, 2'd0, 64'h0000_0000_0000_000f},  // minus one
    '{64'h1234_5678_9abc_def0, 1'b0, 12'h800, 2'd1, 64'h1234_5678_9abc_d6f0},  // most negative
    '{64'h0000_0000_0000_0000, 1'b1, 12'h123, 2'd0, 64'h0000_0000_0000_0000},
    '{64'h0000_0000_0000_0000, 1'b0, 12'h7ff, 2'd2, 64'h0000_0000_0000_07ff},  // nested attempt
    '{64'hffff_ffff_ffff_ffff, 1'b0, 12'h001, 2'd0, 64'h0000_0000_0000_0000},  // wraps to zero
    '{64'h0000_0000_0000_0000, 1'b1, 12'h9a0, 2'd1, 64'h0000_0000_0000_0000},
    '{64'h0000_0000_8000_0000, 1'b0, 12'h7f0, 2'd0, 64'h0000_0000_8000_07f0}
};

// handler writes this lui value, upper 20 bits
localparam logic [19:0] marker_upper = 20'habcde;

`endif

/* tb_rv_core.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core;

    `include "tb_rv_vectors.svh"

    logic                    clk;
    logic                    reset;
    logic [31:0]             instruction;
    logic [63:0]             pc;
    rv_pkg::bus_req_t        bus_req;
    logic [63:0]             bus_read_data;
    logic [3:0]              interrupt_vector;
    logic                    interrupt_ack;
    logic                    heartbeat;

    logic [31:0] prog [n_rows*3 + 16];     // program at ram_base
    logic [31:0] isr  [4];                 // handler at isr_base
    logic [63:0] keys [n_rows];
    logic        irq_done [n_rows];
    logic [63:0] exp_value [$];            // expected art writes in order
    int          exp_row [$];              // row index or -1 for a marker
    integer      seed = 20;
    int          reads_seen;
    int          writes_seen;
    int          total_writes;
    int          acks_seen;
    int          acks_expected;
    int          markers_since_ack;
    int          hb_edges;
    int          irq_phase;
    int          irq_row;                  // row whose interrupt is in flight
    int          fetch_row;
    logic [63:0] marker_value;
    logic [63:0] off;

    rv_core u_rv_core (
        .clk              (clk),
        .reset            (reset),
        .instruction      (instruction),
        .pc               (pc),
        .bus_req          (bus_req),
        .bus_read_data    (bus_read_data),
        .interrupt_vector (interrupt_vector),
        .interrupt_ack    (interrupt_ack),
        .heartbeat        (heartbeat)
    );

    always #2 clk = ~clk;

    // memory follows pc and reads a nop outside the images
    always_comb begin
        instruction = rv_pkg::insn_nop;
        if (pc >= rv_pkg::ram_base && ((pc - rv_pkg::ram_base) >> 2) < n_rows*3 + 16)
            instruction = prog[(pc - rv_pkg::ram_base) >> 2];
        else if (pc < rv_pkg::isr_base + 16)
            instruction = isr[(pc - rv_pkg::isr_base) >> 2];
    end

    function automatic logic [63:0] sext12(input logic [11:0] imm);
        return {{52{imm[11]}}, imm};
    endfunction

    function automatic logic [31:0] encode_addi_x5(input logic [11:0] imm);
        return {imm, 5'd5, 3'b000, 5'd5, 7'b0010011};   // addi x5, x5, imm
    endfunction

    task automatic stop_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_bus(input string name, input rv_pkg::bus_req_t got,
                               input rv_pkg::bus_req_t exp);
        if (got !== exp) begin
            $display("error %s got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic compare_data(input string name, input logic [rv_pkg::xlen-1:0] got,
                                input logic [rv_pkg::xlen-1:0] exp);
        if (got !== exp) begin
            $display("error %s got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error %s got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    // one monitor for bus, interrupt and heartbeat keeps the counters ordered
    always @(posedge clk) begin
        if (reset) begin
            compare_bit("heartbeat", heartbeat, ((hb_edges / rv_pkg::hb_half_period) % 2) == 1);
            hb_edges++;
            if (bus_req.read_enable) begin
                compare_data("bus_req.address", bus_req.address, rv_pkg::key_base);
                if (bus_req.write_enable) begin
                    $display("read and write strobe were high in the same cycle");
                    stop_run();
                end
                if (reads_seen >= n_rows) begin
                    $display("more key loads than rows in the table");
                    stop_run();
                end
                bus_read_data <= keys[reads_seen];
                reads_seen++;
            end
            if (bus_req.write_enable) begin
                if (exp_value.size() == 0) begin
                    $display("write strobe with no store left to expect");
                    stop_run();
                end
                compare_bus("bus_req", bus_req, '{rv_pkg::art_base, exp_value[0], 1'b1, 1'b0});
                if (exp_row[0] < 0)
                    markers_since_ack++;
                else if (reads_seen != exp_row[0] + 1) begin
                    $display("row %0d store without exactly one key load before it", exp_row[0]);
                    stop_run();
                end
                void'(exp_value.pop_front());
                void'(exp_row.pop_front());
                writes_seen++;
            end
            // interrupt source raised while the flagged row's load is fetched
            off = pc - rv_pkg::ram_base;
            fetch_row = int'(off / 12);
            if (interrupt_ack && (irq_phase == 0 || irq_phase == 2)) begin
                $display("interrupt acknowledged while none was pending");
                stop_run();
            end
            case (irq_phase)
                0: if (pc >= rv_pkg::ram_base && off % 12 == 0 && fetch_row < n_rows) begin
                    if (vectors[fetch_row].irq != 2'd0 && !irq_done[fetch_row]) begin
                        irq_done[fetch_row] = 1'b1;
                        irq_row = fetch_row;
                        interrupt_vector <= rv_pkg::irq_external;
                        irq_phase = 1;
                    end
                end
                1: if (interrupt_ack) begin
                    interrupt_vector <= 4'd0;
                    acks_seen++;
                    markers_since_ack = 0;
                    irq_phase = (vectors[irq_row].irq == 2'd2) ? 2 : 0;
                end
                2: begin
                    interrupt_vector <= rv_pkg::irq_external;  // inside the handler while mie is off
                    irq_phase = 3;
                end
                default: if (interrupt_ack) begin
                    if (markers_since_ack == 0) begin
                        $display("second interrupt was taken before the handler returned");
                        stop_run();
                    end
                    interrupt_vector <= 4'd0;
                    acks_seen++;
                    irq_phase = 0;
                end
            endcase
        end
    end

    // watchdog sized per row for loads, handlers and bubbles
    initial begin
        repeat (n_rows * 40 + 100) @(posedge clk);
        $display("timeout, the program did not finish all its stores");
        stop_run();
    end

    initial begin
        clk = 1'b0;
        reset = 1'b0;
        bus_read_data = '0;
        interrupt_vector = 4'd0;
        reads_seen = 0;
        writes_seen = 0;
        acks_seen = 0;
        acks_expected = 0;
        markers_since_ack = 0;
        hb_edges = 0;
        irq_phase = 0;
        irq_row = 0;
        marker_value = {{32{marker_upper[19]}}, marker_upper, 12'b0};
        // program image of three words a row then nops
        for (int i = 0; i < n_rows*3 + 16; i++)
            prog[i] = rv_pkg::insn_nop;
        for (int r = 0; r < n_rows; r++) begin
            irq_done[r] = 1'b0;
            keys[r] = vectors[r].use_random ? {$random(seed), $random(seed)} : vectors[r].key;
            prog[r*3]     = rv_pkg::insn_load_key;
            prog[r*3 + 1] = encode_addi_x5(vectors[r].imm);
            prog[r*3 + 2] = rv_pkg::insn_store_art;
            for (int m = 0; m < int'(vectors[r].irq); m++) begin
                exp_value.push_back(marker_value);
                exp_row.push_back(-1);
                acks_expected++;
            end
            exp_value.push_back(vectors[r].use_random ?
                                keys[r] + sext12(vectors[r].imm) : vectors[r].expect_art);
            exp_row.push_back(r);
        end
        total_writes = exp_value.size();
        isr[0] = {marker_upper, 5'd5, 7'b0110111};  // lui x5, marker
        isr[1] = rv_pkg::insn_store_art;
        isr[2] = rv_pkg::insn_mret;
        isr[3] = rv_pkg::insn_nop;
        repeat (3) @(posedge clk);
        compare_data("pc", pc, rv_pkg::ram_base);
        compare_bit("bus_req.read_enable", bus_req.read_enable, 1'b0);
        compare_bit("bus_req.write_enable", bus_req.write_enable, 1'b0);
        compare_bit("interrupt_ack", interrupt_ack, 1'b0);
        compare_bit("heartbeat", heartbeat, 1'b0);
        @(posedge clk);
        reset <= 1'b1;
        wait (writes_seen == total_writes);
        repeat (10) @(posedge clk);    // catch stray strobes or acks
        compare_data("acks_seen", 64'(acks_seen), 64'(acks_expected));
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+.
rv_pkg.sv
rv_decode.sv
rv_regfile.sv
rv_csr.sv
rv_heartbeat.sv
rv_exec_fsm.sv
rv_core.sv
tb_rv_core.sv

/* Makefile */
SRCS := rv_pkg.sv rv_decode.sv rv_regfile.sv rv_csr.sv rv_heartbeat.sv \
        rv_exec_fsm.sv rv_core.sv tb_rv_core.sv tb_rv_vectors.svh

.PHONY: all run clean

all: obj_dir/Vtb_rv_core

obj_dir/Vtb_rv_core: sources.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_rv_core -f sources.f

run: obj_dir/Vtb_rv_core
	./obj_dir/Vtb_rv_core | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
